// ==== tb.f ====
hdl/key_exp_pkg.sv
hdl/aes_sbox.sv
hdl/key_exp_datapath.sv
hdl/key_exp_control.sv
hdl/round_key_store.sv
hdl/key_exp_apb.sv
hdl/key_exp_top.sv
verif/key_exp_tb.sv

// ==== Makefile ====
TB = key_exp_tb

.PHONY: all run lint clean

all: run

run:
	verilator --binary --timing -j 0 --top-module $(TB) -f tb.f
	./obj_dir/V$(TB)

lint:
	verilator --lint-only --timing --top-module $(TB) -f tb.f

clean:
	rm -rf obj_dir

// ==== verif/key_exp_tb.sv ====
module key_exp_tb;

    // table row with a cipher key and the round keys it must expand to
    typedef struct packed {
        logic [127:0] key;
        logic [127:0] rk1;
        logic [127:0] rk10;
    } vec_t;

    logic                  clk;
    logic                  rst;
    key_exp_pkg::apb_req_t apb_req;
    key_exp_pkg::apb_rsp_t apb_rsp;
    logic                  irq;

    vec_t        vecs [2];
    integer      seed;
    int unsigned cyc = 0;   // free-running cycle count for timeouts
    logic        irq_seen;  // irq during the access cycle of the last transfer

    key_exp_top key_exp_top_i (
        .clk     (clk),
        .rst     (rst),
        .apb_req (apb_req),
        .apb_rsp (apb_rsp),
        .irq     (irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    task automatic stop_on_error(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_word(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
            stop_on_error($sformatf("Mismatch %s: expected %h, got %h", name, exp, act));
    endtask

    task automatic check_rsp(input string name, input key_exp_pkg::apb_rsp_t act,
                             input logic exp_err);
        if (act.pready !== 1'b1)
            stop_on_error($sformatf("Mismatch %s pready: expected 1, got %h", name, act.pready));
        if (act.pslverr !== exp_err)
            stop_on_error($sformatf("Mismatch %s pslverr: expected %h, got %h",
                                    name, exp_err, act.pslverr));
    endtask

    // setup cycle, access cycle, then idle
    task automatic apb_xfer(input logic write, input logic [7:0] addr, input logic [31:0] wdata,
                            output key_exp_pkg::apb_rsp_t rsp);
        @(posedge clk);
        apb_req.paddr   <= addr;
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.pwdata  <= wdata;
        @(posedge clk);
        apb_req.penable <= 1'b1;
        @(negedge clk);      // response valid mid access cycle
        rsp      = apb_rsp;
        irq_seen = irq;
        @(posedge clk);      // transfer completes on this edge
        apb_req.psel    <= 1'b0;
        apb_req.penable <= 1'b0;
    endtask

    task automatic write_reg(input logic [7:0] addr, input logic [31:0] data,
                             input logic exp_err, input string name);
        key_exp_pkg::apb_rsp_t rsp;
        apb_xfer(1'b1, addr, data, rsp);
        check_rsp(name, rsp, exp_err);
    endtask

    task automatic read_reg(input logic [7:0] addr, input logic [31:0] exp, input string name);
        key_exp_pkg::apb_rsp_t rsp;
        apb_xfer(1'b0, addr, 32'h0, rsp);
        check_rsp(name, rsp, 1'b0);
        check_word($sformatf("%s prdata", name), exp, rsp.prdata);
    endtask

    // byte 0 goes in the top of word 0
    task automatic load_key(input logic [127:0] key);
        for (int i = 0; i < 4; i++)
        begin
            write_reg(8'(key_exp_pkg::REG_KEY + 4 * i), key[127 - 32 * i -: 32], 1'b0,
                      $sformatf("key word %0d write", i));
        end
    endtask

    task automatic check_round_key(input int round, input logic [127:0] exp);
        for (int w = 0; w < 4; w++)
        begin
            read_reg(8'(key_exp_pkg::REG_RKEY + 16 * round + 4 * w), exp[127 - 32 * w -: 32],
                     $sformatf("round %0d word %0d", round, w));
        end
    endtask

    // the status read that sees done also clears it
    task automatic wait_done();
        key_exp_pkg::apb_rsp_t rsp;
        int unsigned t0;
        logic finished;
        t0       = cyc;
        finished = 1'b0;
        while (!finished && (cyc - t0 < 1000))
        begin
            apb_xfer(1'b0, key_exp_pkg::REG_STATUS, 32'h0, rsp);
            check_rsp("status poll", rsp, 1'b0);
            finished = rsp.prdata[1];
        end
        if (!finished)
            stop_on_error("timeout: done was not set within 1000 cycles of polling");
        check_word("irq before status read", 32'h1, {31'h0, irq_seen});
        check_word("busy with done", 32'h0, {31'h0, rsp.prdata[0]});
    endtask

    task automatic run_and_check(input vec_t v);
        write_reg(key_exp_pkg::REG_CTRL, 32'h1, 1'b0, "start");
        write_reg(key_exp_pkg::REG_KEY, ~v.key[127:96], 1'b1, "key write while busy");
        read_reg(key_exp_pkg::REG_KEY, v.key[127:96], "key word 0 while busy");  // unchanged
        wait_done();
        read_reg(key_exp_pkg::REG_STATUS, 32'h0, "status after clear");
        check_word("irq after status read", 32'h0, {31'h0, irq_seen});
        check_round_key(0, v.key);   // round 0 is the key itself
        check_round_key(1, v.rk1);
        check_round_key(10, v.rk10);
    endtask

    initial
    begin
        logic [7:0]            addr;
        key_exp_pkg::apb_rsp_t rsp;
        seed    = 5824;
        rst     = 1'b1;
        apb_req = '0;
        vecs[0] = {128'h2b7e151628aed2a6abf7158809cf4f3c,
                   128'ha0fafe1788542cb123a339392a6c7605,
                   128'hd014f9a8c9ee2589e13f0cc8b6630ca6};
        vecs[1] = {128'h0,
                   128'h62636363626363636263636362636363,
                   128'hb4ef5bcb3e92e21123e951cf6f8f188e};
        repeat (10) @(posedge clk);
        rst <= 1'b0;

        read_reg(key_exp_pkg::REG_STATUS, 32'h0, "status after reset");
        check_word("irq after reset", 32'h0, {31'h0, irq_seen});
        read_reg(key_exp_pkg::REG_RKEY, 32'h0, "round 0 word 0 after reset");

        for (int i = 0; i < 2; i++)
        begin
            load_key(vecs[i].key);
            run_and_check(vecs[i]);
        end

        // 0x20..0x3f sits between the key and round key windows
        addr = 8'h20 | 8'($random(seed) & 31);
        apb_xfer(1'b0, addr, 32'h0, rsp);
        check_rsp($sformatf("unmapped read at %h", addr), rsp, 1'b1);
        write_reg(8'(key_exp_pkg::REG_RKEY + 16), 32'hdeadbeef, 1'b1, "round key write");

        load_key(vecs[0].key);
        run_and_check(vecs[0]);
        run_and_check(vecs[0]);  // restart with the key registers untouched

        $display("sim passed");
        $finish;
    end

endmodule

// ==== hdl/key_exp_top.sv ====
module key_exp_top (
    input  logic                  clk,
    input  logic                  rst,
    input  key_exp_pkg::apb_req_t apb_req,
    output key_exp_pkg::apb_rsp_t apb_rsp,
    output logic                  irq
);

    key_exp_pkg::kx_sel_t sel;
    logic                 start;
    logic                 busy;
    logic                 done_pulse;
    logic                 round_wr;
    logic [3:0]           wr_round;
    logic [3:0]           load_byte_idx;
    logic [127:0]         key;
    logic [127:0]         key_state;
    logic [5:0]           rkey_idx;
    logic [31:0]          rkey_word;

    key_exp_apb key_exp_apb_i (
        .clk        (clk),
        .rst        (rst),
        .apb_req    (apb_req),
        .apb_rsp    (apb_rsp),
        .busy       (busy),
        .done_pulse (done_pulse),
        .rkey_word  (rkey_word),
        .key        (key),
        .start      (start),
        .rkey_idx   (rkey_idx),
        .irq        (irq)
    );

    key_exp_control key_exp_control_i (
        .clk           (clk),
        .rst           (rst),
        .start         (start),
        .sel           (sel),
        .load_byte_idx (load_byte_idx),
        .round_wr      (round_wr),
        .wr_round      (wr_round),
        .busy          (busy),
        .done_pulse    (done_pulse)
    );

    key_exp_datapath key_exp_datapath_i (
        .clk           (clk),
        .key           (key),
        .load_byte_idx (load_byte_idx),
        .sel           (sel),
        .key_state     (key_state)
    );

    round_key_store round_key_store_i (
        .clk       (clk),
        .rst       (rst),
        .round_wr  (round_wr),
        .wr_round  (wr_round),
        .key_state (key_state),
        .rkey_idx  (rkey_idx),
        .rkey_word (rkey_word)
    );

endmodule

// ==== hdl/key_exp_apb.sv ====
module key_exp_apb (
    input  logic                  clk,
    input  logic                  rst,
    input  key_exp_pkg::apb_req_t apb_req,
    output key_exp_pkg::apb_rsp_t apb_rsp,
    input  logic                  busy,
    input  logic                  done_pulse,
    input  logic [31:0]           rkey_word,
    output logic [127:0]          key,
    output logic                  start,
    output logic [5:0]            rkey_idx,
    output logic                  irq
);

    logic [31:0] key_word [4];  // word 0 holds key bytes 0..3
    logic        done;
    logic        access;        // access phase of a transfer
    logic        is_ctrl;
    logic        is_status;
    logic        is_key;
    logic        is_rkey;
    logic [7:0]  rkey_off;      // offset into the round key window

    assign access    = apb_req.psel && apb_req.penable;
    assign is_ctrl   = (apb_req.paddr == key_exp_pkg::REG_CTRL);
    assign is_status = (apb_req.paddr == key_exp_pkg::REG_STATUS);
    assign is_key    = ((apb_req.paddr & 8'hf0) == key_exp_pkg::REG_KEY)
                    && (apb_req.paddr[1:0] == 2'b00);
    assign rkey_off  = apb_req.paddr - key_exp_pkg::REG_RKEY;
    assign is_rkey   = (apb_req.paddr >= key_exp_pkg::REG_RKEY)
                    && (rkey_off[7:4] <= 4'(key_exp_pkg::NUM_ROUNDS))
                    && (apb_req.paddr[1:0] == 2'b00);
    assign rkey_idx  = rkey_off[7:2];  // round in 5:2, word in 1:0

    // start is dropped while a run is in progress
    assign start = access && apb_req.pwrite && is_ctrl && apb_req.pwdata[0] && !busy;
    assign key   = {key_word[0], key_word[1], key_word[2], key_word[3]};
    assign irq   = done;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < 4; i++)
            begin
                key_word[i] <= 32'h0;
            end
            done <= 1'b0;
        end
        else
        begin
            if (access && apb_req.pwrite && is_key && !busy)
                key_word[apb_req.paddr[3:2]] <= apb_req.pwdata;
            if (done_pulse)
                done <= 1'b1;  // a finishing run wins over a status read
            else if (access && !apb_req.pwrite && is_status)
                done <= 1'b0;  // read to clear
        end
    end

    always_comb
    begin
        apb_rsp.pready = 1'b1;  // no wait states
        apb_rsp.prdata = 32'h0;
        if (is_status)
            apb_rsp.prdata = {30'h0, done, busy};
        else if (is_key)
            apb_rsp.prdata = key_word[apb_req.paddr[3:2]];
        else if (is_rkey)
            apb_rsp.prdata = rkey_word;  // store read is combinational
        // unmapped addresses, bad writes, key writes during a run
        apb_rsp.pslverr = access
                       && (!(is_ctrl || is_status || is_key || is_rkey)
                       || (apb_req.pwrite && is_rkey)
                       || (apb_req.pwrite && is_key && busy));
    end

endmodule

// ==== hdl/round_key_store.sv ====
module round_key_store (
    input  logic         clk,
    input  logic         rst,
    input  logic         round_wr,
    input  logic [3:0]   wr_round,
    input  logic [127:0] key_state,
    input  logic [5:0]   rkey_idx,   // {round, word}
    output logic [31:0]  rkey_word
);

    logic [127:0] keys [key_exp_pkg::NUM_ROUNDS + 1];  // round 0 is the cipher key
    logic [3:0]   rd_round;
    logic [1:0]   rd_word;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i <= key_exp_pkg::NUM_ROUNDS; i++)
            begin
                keys[i] <= '0;
            end
        end
        else if (round_wr && (wr_round <= 4'(key_exp_pkg::NUM_ROUNDS)))
        begin
            keys[wr_round] <= key_state;  // whole round key at once
        end
    end

    assign rd_round = rkey_idx[5:2];
    assign rd_word  = rkey_idx[1:0];

    // word 0 is the top 32 bits
    always_comb
    begin
        if (rd_round <= 4'(key_exp_pkg::NUM_ROUNDS))
            rkey_word = keys[rd_round][32 * (2'd3 - rd_word) +: 32];
        else
            rkey_word = 32'h0;  // rounds 11..15 read as zero
    end

endmodule

// ==== hdl/key_exp_control.sv ====
module key_exp_control (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 start,
    output key_exp_pkg::kx_sel_t sel,
    output logic [3:0]           load_byte_idx,
    output logic                 round_wr,       // one cycle after the round key settles
    output logic [3:0]           wr_round,
    output logic                 busy,
    output logic                 done_pulse      // last cycle of round 10
);

    key_exp_pkg::kx_state_e state;
    logic [3:0] cnt;    // cycles spent in the current state
    logic [3:0] round;  // round in progress, 1..10

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= key_exp_pkg::IDLE;
            cnt      <= 4'd0;
            round    <= 4'd0;
            round_wr <= 1'b0;
            wr_round <= 4'd0;
        end
        else
        begin
            round_wr <= 1'b0;
            case (state)
                key_exp_pkg::IDLE:
                begin
                    cnt <= 4'd0;
                    if (start)
                        state <= key_exp_pkg::LOAD;
                end
                key_exp_pkg::LOAD:  // 16 cycles
                begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'(key_exp_pkg::NUM_BYTES - 1))
                    begin
                        state    <= key_exp_pkg::ONE;
                        cnt      <= 4'd0;
                        round    <= 4'd1;
                        round_wr <= 1'b1;  // the cipher key is round key 0
                        wr_round <= 4'd0;
                    end
                end
                key_exp_pkg::ONE:
                begin
                    state <= key_exp_pkg::TWO;
                    cnt   <= 4'd0;
                end
                key_exp_pkg::TWO:   // 2 cycles
                begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd1)
                    begin
                        state <= key_exp_pkg::THREE;
                        cnt   <= 4'd0;
                    end
                end
                key_exp_pkg::THREE:
                begin
                    state <= key_exp_pkg::NORM;
                    cnt   <= 4'd0;
                end
                key_exp_pkg::NORM:  // 8 cycles
                begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd7)
                    begin
                        state <= key_exp_pkg::SHIFT;
                        cnt   <= 4'd0;
                    end
                end
                key_exp_pkg::SHIFT: // 4 cycles, round ends here
                begin
                    cnt <= cnt + 4'd1;
                    if (cnt == 4'd3)
                    begin
                        cnt      <= 4'd0;
                        round_wr <= 1'b1;
                        wr_round <= round;
                        round    <= round + 4'd1;
                        if (round == 4'(key_exp_pkg::NUM_ROUNDS))
                            state <= key_exp_pkg::IDLE;
                        else
                            state <= key_exp_pkg::ONE;
                    end
                end
                default:
                    state <= key_exp_pkg::IDLE;
            endcase
        end
    end

    assign busy          = (state != key_exp_pkg::IDLE);
    assign load_byte_idx = (state == key_exp_pkg::LOAD) ? cnt : 4'd0;
    assign done_pulse    = (state == key_exp_pkg::SHIFT) && (cnt == 4'd3)
                        && (round == 4'(key_exp_pkg::NUM_ROUNDS));

    // select decode per state
    always_comb
    begin
        sel = '0;  // idle
        case (state)
            key_exp_pkg::LOAD:
            begin
                sel.select_sbox = 1'b1;     // bit_out low, hold follows r13
            end
            key_exp_pkg::ONE:
            begin
                sel.select_input   = 1'b1;
                sel.select_sbox    = 1'b1;
                sel.select_bit_out = 1'b1;
                sel.rcon_en        = 8'hff; // rcon into byte 0
            end
            key_exp_pkg::TWO:
            begin
                sel.select_input   = 1'b1;
                sel.select_sbox    = 1'b1;
                sel.select_bit_out = 1'b1;
            end
            key_exp_pkg::THREE:
            begin
                sel.select_input   = 1'b1;  // s-box takes the held byte
                sel.select_bit_out = 1'b1;
            end
            key_exp_pkg::NORM:
            begin
                sel.select_input    = 1'b1;
                sel.select_last_out = 1'b1;
                sel.select_bit_out  = 1'b1;
            end
            key_exp_pkg::SHIFT:
            begin
                sel.select_input    = 1'b1;
                sel.select_last_out = 1'b1; // hold picks up the next byte 12
            end
            default:
            begin
                sel = '0;
            end
        endcase
    end

endmodule

// ==== hdl/key_exp_datapath.sv ====
module key_exp_datapath (
    input  logic                 clk,
    input  logic [127:0]         key,            // fips-197 order, byte 0 in 127:120
    input  logic [3:0]           load_byte_idx,
    input  key_exp_pkg::kx_sel_t sel,
    output logic [127:0]         key_state       // r0 in 127:120
);

    // r[0] leaves first, new bytes enter at r[15]
    logic [7:0] r [key_exp_pkg::NUM_BYTES];
    logic [7:0] hold_byte;   // byte 12 of the current round key
    logic [7:0] rcon;        // round constant
    logic [7:0] key_byte;    // key byte picked during load
    logic [7:0] sbox_in;
    logic [7:0] sbox_out;
    logic [7:0] sub_byte;    // s-box output with rcon folded in
    logic [7:0] feedback;
    logic [7:0] round_byte;  // next round key byte
    logic [7:0] new_byte;    // byte entering r15

    assign key_byte = key[8 * (4'd15 - load_byte_idx) +: 8];

    // s-box reads r13 for bytes 0..2 and the held byte 12 for byte 3
    assign sbox_in = sel.select_sbox ? r[13] : hold_byte;

    aes_sbox aes_sbox_i (
        .in_byte  (sbox_in),
        .out_byte (sbox_out)
    );

    assign sub_byte   = sbox_out ^ (rcon & sel.rcon_en);     // rcon only on byte 0
    assign feedback   = sel.select_last_out ? r[12] : sub_byte; // r12 is new byte t-4
    assign round_byte = r[0] ^ feedback;                      // r0 is old byte t
    assign new_byte   = sel.select_input ? round_byte : key_byte;

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < key_exp_pkg::NUM_BYTES - 1; i++)
        begin
            r[i] <= r[i + 1];  // one byte per clock
        end
        r[key_exp_pkg::NUM_BYTES - 1] <= new_byte;

        // r13 holds the next byte 12 in the last cycle of load and shift
        if (!sel.select_bit_out)
            hold_byte <= r[13];

        if (!sel.select_input)
            rcon <= 8'h01;                       // restart at x^0 for each run
        else if (|sel.rcon_en)
            rcon <= key_exp_pkg::xtime(rcon);    // step once per round, after use
    end

    // flatten the shift register, r0 on top
    always_comb
    begin
        for (int i = 0; i < key_exp_pkg::NUM_BYTES; i++)
        begin
            key_state[127 - 8 * i -: 8] = r[i];
        end
    end

endmodule

// ==== hdl/aes_sbox.sv ====
module aes_sbox (
    input  logic [7:0] in_byte,
    output logic [7:0] out_byte
);

    logic [7:0] x2;    // powers of the input byte
    logic [7:0] x3;
    logic [7:0] x6;
    logic [7:0] x12;
    logic [7:0] x15;
    logic [7:0] x30;
    logic [7:0] x60;
    logic [7:0] x120;
    logic [7:0] x240;
    logic [7:0] x252;
    logic [7:0] inv;   // x^254, the multiplicative inverse (0 maps to 0)

    // shift-and-add multiply in gf(2^8)
    function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] sh;
        acc = 8'h00;
        sh  = a;
        for (int i = 0; i < 8; i++)
        begin
            if (b[i])
                acc = acc ^ sh;  // add this partial product
            sh = key_exp_pkg::xtime(sh);
        end
        return acc;
    endfunction

    // addition chain for x^254
    always_comb
    begin
        x2   = gf_mul(in_byte, in_byte);
        x3   = gf_mul(x2, in_byte);
        x6   = gf_mul(x3, x3);
        x12  = gf_mul(x6, x6);
        x15  = gf_mul(x12, x3);
        x30  = gf_mul(x15, x15);
        x60  = gf_mul(x30, x30);
        x120 = gf_mul(x60, x60);
        x240 = gf_mul(x120, x120);
        x252 = gf_mul(x240, x12);
        inv  = gf_mul(x252, x2);  // 240 + 12 + 2
    end

    // affine transform, constant 0x63
    always_comb
    begin
        for (int i = 0; i < 8; i++)
        begin
            out_byte[i] = inv[i] ^ inv[(i + 4) % 8] ^ inv[(i + 5) % 8]
                        ^ inv[(i + 6) % 8] ^ inv[(i + 7) % 8];
        end
        out_byte = out_byte ^ 8'h63;
    end

endmodule

// ==== hdl/key_exp_pkg.sv ====
package key_exp_pkg;

    // apb request as seen by the slave
    typedef struct packed {
        logic [7:0]  paddr;   // byte address
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [31:0] pwdata;
    } apb_req_t;

    // apb response, zero wait states
    typedef struct packed {
        logic [31:0] prdata;
        logic        pready;   // always 1
        logic        pslverr;
    } apb_rsp_t;

    // key expansion controller states
    typedef enum logic [2:0] {
        IDLE,
        LOAD,   // key bytes shifted in
        ONE,    // byte 0 of round, rcon applied
        TWO,    // bytes 1 and 2 through the s-box
        THREE,  // byte 3 from the held byte 12
        NORM,   // bytes 4..11, plain xor chain
        SHIFT   // bytes 12..15, last column
    } kx_state_e;

    // datapath mux selects and rcon mask
    typedef struct packed {
        logic       select_input;     // 0 loads key bytes, 1 feeds back round bytes
        logic       select_sbox;      // 1 s-box reads r13, 0 reads the held byte
        logic       select_last_out;  // 1 xors r0 with r12 instead of the s-box path
        logic       select_bit_out;   // 0 lets the hold register follow r13
        logic [7:0] rcon_en;          // mask for the round constant
    } kx_sel_t;

    localparam int NUM_BYTES  = 16;  // aes-128 key bytes
    localparam int NUM_ROUNDS = 10;  // aes-128 rounds

    localparam logic [7:0] REG_CTRL   = 8'h00;
    localparam logic [7:0] REG_STATUS = 8'h04;
    localparam logic [7:0] REG_KEY    = 8'h10;  // four words up to 0x1c
    localparam logic [7:0] REG_RKEY   = 8'h40;  // 16 bytes per round key

    // multiply by x in gf(2^8) with the aes polynomial
    function automatic logic [7:0] xtime(input logic [7:0] a);
        return {a[6:0], 1'b0} ^ (a[7] ? 8'h1b : 8'h00);
    endfunction

endpackage
